//--- Makefile
VERILATOR ?= verilator
TOP       ?= vga_frame_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LOG       ?= sim.log
FAIL_MSG  ?= Errors found

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axil_read_if.sv
`timescale 1ns/1ps

interface axil_read_if;

  // read address channel
  logic [vga_pkg::ADDR_W-1:0] araddr;
  logic                       arvalid;
  logic                       arready;

  // read data channel, data kept in its pixel word form
  vga_pkg::pixel_word_u       rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  // slave side is shared by the router (ar) and the merge (r)
  modport slave (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

//--- sram_access_router.sv
`timescale 1ns/1ps

module sram_access_router (
  input  logic                                clk,
  input  logic                                reset,
  axil_read_if.slave                          rd,
  input  logic                                load_en,
  input  logic [vga_pkg::ADDR_W-1:0]          load_addr,
  input  logic [vga_pkg::DATA_W-1:0]          load_data,
  input  logic                                busy,
  output logic [vga_pkg::BANK_COUNT-1:0]      bank_rd,
  output logic [vga_pkg::BANK_COUNT-1:0]      bank_wr,
  output logic [vga_pkg::BANK_ADDR_W-1:0]     bank_addr,
  output logic [vga_pkg::DATA_W-1:0]          bank_wdata,
  output logic [vga_pkg::BANK_SEL_W-1:0]      rsp_bank
);

  logic                             rd_fire;
  logic [vga_pkg::ADDR_W-1:0]       sel_addr;
  logic [vga_pkg::BANK_SEL_W-1:0]   sel_bank;

  // loads win, and a pending response stalls new reads
  assign rd.arready = !busy && !load_en;
  assign rd_fire    = rd.arvalid && rd.arready;

  // low bits pick the bank, upper bits the word inside it
  assign sel_addr  = load_en ? load_addr : rd.araddr;
  assign sel_bank  = sel_addr[vga_pkg::BANK_SEL_W-1:0];
  assign bank_addr = sel_addr[vga_pkg::ADDR_W-1:vga_pkg::BANK_SEL_W];

  assign bank_wdata = load_data;

  // one hot strobes toward the banks
  always_comb begin
    bank_rd = '0;
    bank_wr = '0;
    bank_rd[sel_bank] = rd_fire;
    bank_wr[sel_bank] = load_en;
  end

  // bank index follows the read into the bank stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_bank <= '0;
    end else if (rd_fire) begin
      rsp_bank <= sel_bank;
    end
  end

endmodule

//--- sram_bank.sv
`timescale 1ns/1ps

module sram_bank (
  input  logic                             clk,
  input  logic                             rd,
  input  logic                             wr,
  input  logic [vga_pkg::BANK_ADDR_W-1:0]  addr,
  input  logic [vga_pkg::DATA_W-1:0]       wdata,
  output logic [vga_pkg::DATA_W-1:0]       rdata
);

  localparam int DEPTH = 2 ** vga_pkg::BANK_ADDR_W;

  logic [vga_pkg::DATA_W-1:0] mem [DEPTH];

  // single port, router never asks for both at once
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[addr] <= wdata;
    end
  end

  // read word lands one cycle after the strobe
  // and holds until the next read
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[addr];
    end
  end

endmodule

//--- sram_read_merge.sv
`timescale 1ns/1ps

module sram_read_merge (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic [vga_pkg::BANK_SEL_W-1:0]                     rsp_bank,
  input  logic [vga_pkg::BANK_COUNT-1:0][vga_pkg::DATA_W-1:0] bank_rdata,
  axil_read_if.slave                                         rd,
  output logic                                               busy
);

  logic stage_valid;

  // a read accepted last cycle now has its word at the bank output
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= rd.arvalid && rd.arready;
    end
  end

  // output register is free whenever stage_valid is set,
  // since busy kept the router from accepting over a held response
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd.rvalid <= 1'b0;
    end else if (stage_valid) begin
      rd.rvalid <= 1'b1;
    end else if (rd.rready) begin
      rd.rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_valid) begin
      rd.rdata.raw <= bank_rdata[rsp_bank];
    end
  end

  assign rd.rresp = vga_pkg::RESP_OKAY;

  // bank stage in use, or response not yet taken
  assign busy = stage_valid || (rd.rvalid && !rd.rready);

endmodule

//--- tb.f
vga_pkg.sv
axil_read_if.sv
vga_sram_pixel_stream.sv
sram_access_router.sv
sram_bank.sv
sram_read_merge.sv
vga_frame_top.sv
vga_frame_checker.sv
vga_frame_tb.sv

//--- vga_frame_checker.sv
`timescale 1ns/1ps

module vga_frame_checker (
  input logic                       clk,
  input logic                       reset,
  input logic [vga_pkg::ADDR_W-1:0] araddr,
  input logic                       arvalid,
  input logic                       arready,
  input logic                       rvalid,
  input logic                       rready,
  input logic                       valid
);

  // read address request stays up until the router takes it
  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");

  // address must not move while the request waits
  ar_stable: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> $stable(araddr))
    else $error("araddr changed while arvalid was waiting");

  // one strobe per pixel, never back to back
  valid_pulse: assert property (@(posedge clk) disable iff (reset)
    valid |=> !valid)
    else $error("valid high on two consecutive cycles");

  // response held by the merge until the streamer takes it
  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

//--- vga_frame_tb.sv
`timescale 1ns/1ps

module vga_frame_tb;

  localparam int ROWS        = 5;
  localparam int FRAME_WORDS = 2 ** vga_pkg::ADDR_W;

  logic                       clk;
  logic                       reset;
  logic                       enable;
  logic                       load_en;
  logic [vga_pkg::ADDR_W-1:0] load_addr;
  logic [vga_pkg::DATA_W-1:0] load_data;
  logic                       hsync;
  logic                       vsync;
  logic [3:0]                 red;
  logic [3:0]                 green;
  logic [3:0]                 blue;
  logic                       valid;

  // scenario table, one entry per row
  // pixels to observe, enable low gap before the row, reload before the row
  // a reload row needs a gap long enough to drain the reads in flight
  int row_pixels [ROWS] = '{100, 200, 40, 300, 60};
  int row_gap    [ROWS] = '{0, 12, 1, 10, 3};
  bit row_reload [ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  // model of the frame memory and of the display raster
  logic [vga_pkg::DATA_W-1:0] model_mem [FRAME_WORDS];
  logic [31:0]                seed;
  int                         col;
  int                         row;
  int                         pix_seen;
  bit                         streaming;

  vga_frame_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .hsync     (hsync),
    .vsync     (vsync),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .valid     (valid)
  );

  bind vga_frame_top vga_frame_checker checker_i (
    .clk     (clk),
    .reset   (reset),
    .araddr  (rd_bus.araddr),
    .arvalid (rd_bus.arvalid),
    .arready (rd_bus.arready),
    .rvalid  (rd_bus.rvalid),
    .rready  (rd_bus.rready),
    .valid   (valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // run budget in cycles, 8 per table pixel plus reset, gaps and loads
  function automatic int watchdog_cycles();
    int cycles;
    cycles = 16 + FRAME_WORDS;
    for (int i = 0; i < ROWS; i++) begin
      cycles += 8 * row_pixels[i] + row_gap[i];
      if (row_reload[i]) begin
        cycles += FRAME_WORDS;
      end
    end
    return cycles;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got %h, expected %h", name, actual, expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // writes a fresh random frame through the load port, one word per cycle
  task automatic load_frame();
    for (int i = 0; i < FRAME_WORDS; i++) begin
      seed         = next_random(seed);
      model_mem[i] = seed[31:16];
      load_en      = 1'b1;
      load_addr    = i[vga_pkg::ADDR_W-1:0];
      load_data    = seed[31:16];
      @(posedge clk);
      #10;
    end
    load_en = 1'b0;
  endtask

  // sampled mid cycle, away from the edge that updates the outputs
  always @(negedge clk) begin : monitor
    logic [vga_pkg::DATA_W-1:0] word;
    logic                       vis;
    logic                       hs_exp;
    logic                       vs_exp;
    if (!reset && !streaming) begin
      // nothing moves before the first enable
      expect_equal("valid", valid, 0);
      expect_equal("arvalid", dut_i.rd_bus.arvalid, 0);
      expect_equal("hsync", hsync, 0);
      expect_equal("vsync", vsync, 0);
      expect_equal("red", red, 0);
      expect_equal("green", green, 0);
      expect_equal("blue", blue, 0);
    end
    if (valid) begin
      vis  = (col < vga_pkg::H_VISIBLE) && (row < vga_pkg::V_VISIBLE);
      // visible words are packed row after row from address 0
      word = vis ? model_mem[row * vga_pkg::H_VISIBLE + col] : '0;
      // syncs low only inside their pulse after the front porch
      hs_exp = !(col >= vga_pkg::H_VISIBLE + vga_pkg::H_FRONT_PORCH &&
                 col < vga_pkg::H_VISIBLE + vga_pkg::H_FRONT_PORCH + vga_pkg::H_SYNC_PULSE);
      vs_exp = !(row >= vga_pkg::V_VISIBLE + vga_pkg::V_FRONT_PORCH &&
                 row < vga_pkg::V_VISIBLE + vga_pkg::V_FRONT_PORCH + vga_pkg::V_SYNC_PULSE);
      expect_equal("hsync", hsync, hs_exp);
      expect_equal("vsync", vsync, vs_exp);
      expect_equal("red", red, word[15:12]);
      expect_equal("green", green, word[11:8]);
      expect_equal("blue", blue, word[7:4]);
      pix_seen++;
      // model raster, 24 columns by 12 rows
      if (col == vga_pkg::H_WHOLE_LINE - 1) begin
        col = 0;
        if (row == vga_pkg::V_WHOLE_FRAME - 1) begin
          row = 0;
        end else begin
          row++;
        end
      end else begin
        col++;
      end
    end
  end

  initial begin
    int target;
    reset     = 1'b1;
    enable    = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    seed      = 32'hb6c2;
    col       = 0;
    row       = 0;
    pix_seen  = 0;
    streaming = 1'b0;
    target    = 0;
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    load_frame();
    for (int i = 0; i < ROWS; i++) begin
      if (row_gap[i] > 0) begin
        enable = 1'b0;
        repeat (row_gap[i]) begin
          @(posedge clk);
          #10;
        end
      end
      if (row_reload[i]) begin
        load_frame();
      end
      streaming = 1'b1;
      enable    = 1'b1;
      // reads in flight may overshoot, the next row counts from there
      target += row_pixels[i];
      wait (pix_seen >= target);
      @(posedge clk);
      #10;
    end
    enable = 1'b0;
    $display("No errors");
    $finish;
  end

  // ends a stalled run
  initial begin : watchdog
    repeat (watchdog_cycles()) @(posedge clk);
    $display("timeout: pixel stream stalled");
    $display("Errors found");
    $fatal(1);
  end

endmodule

//--- vga_frame_top.sv
`timescale 1ns/1ps

module vga_frame_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic                         load_en,
  input  logic [vga_pkg::ADDR_W-1:0]   load_addr,
  input  logic [vga_pkg::DATA_W-1:0]   load_data,
  output logic                         hsync,
  output logic                         vsync,
  output logic [3:0]                   red,
  output logic [3:0]                   green,
  output logic [3:0]                   blue,
  output logic                         valid
);

  logic [vga_pkg::BANK_COUNT-1:0]                      bank_rd;
  logic [vga_pkg::BANK_COUNT-1:0]                      bank_wr;
  logic [vga_pkg::BANK_ADDR_W-1:0]                     bank_addr;
  logic [vga_pkg::DATA_W-1:0]                          bank_wdata;
  logic [vga_pkg::BANK_COUNT-1:0][vga_pkg::DATA_W-1:0] bank_rdata;
  logic [vga_pkg::BANK_SEL_W-1:0]                      rsp_bank;
  logic                                                busy;

  axil_read_if rd_bus ();

  vga_sram_pixel_stream stream_i (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .rd     (rd_bus.master),
    .hsync  (hsync),
    .vsync  (vsync),
    .red    (red),
    .green  (green),
    .blue   (blue),
    .valid  (valid)
  );

  // address channel side of the slave
  sram_access_router router_i (
    .clk        (clk),
    .reset      (reset),
    .rd         (rd_bus.slave),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .busy       (busy),
    .bank_rd    (bank_rd),
    .bank_wr    (bank_wr),
    .bank_addr  (bank_addr),
    .bank_wdata (bank_wdata),
    .rsp_bank   (rsp_bank)
  );

  // banks share address and write data, strobes are per bank
  for (genvar g = 0; g < vga_pkg::BANK_COUNT; g++) begin : g_bank
    sram_bank bank_i (
      .clk   (clk),
      .rd    (bank_rd[g]),
      .wr    (bank_wr[g]),
      .addr  (bank_addr),
      .wdata (bank_wdata),
      .rdata (bank_rdata[g])
    );
  end

  // data channel side of the slave
  sram_read_merge merge_i (
    .clk        (clk),
    .reset      (reset),
    .rsp_bank   (rsp_bank),
    .bank_rdata (bank_rdata),
    .rd         (rd_bus.slave),
    .busy       (busy)
  );

endmodule

//--- vga_pkg.sv
package vga_pkg;

  // raster counters, wide enough for the whole line of 24 columns
  localparam int COORD_W = 5;

  // horizontal timing in columns
  localparam logic [COORD_W-1:0] H_VISIBLE     = 5'd16;
  localparam logic [COORD_W-1:0] H_FRONT_PORCH = 5'd2;
  localparam logic [COORD_W-1:0] H_SYNC_PULSE  = 5'd3;
  localparam logic [COORD_W-1:0] H_WHOLE_LINE  = 5'd24;

  // vertical timing in rows
  localparam logic [COORD_W-1:0] V_VISIBLE     = 5'd8;
  localparam logic [COORD_W-1:0] V_FRONT_PORCH = 5'd1;
  localparam logic [COORD_W-1:0] V_SYNC_PULSE  = 5'd2;
  localparam logic [COORD_W-1:0] V_WHOLE_FRAME = 5'd12;

  // sync windows are [start, end)
  localparam logic [COORD_W-1:0] H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam logic [COORD_W-1:0] H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
  localparam logic [COORD_W-1:0] V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam logic [COORD_W-1:0] V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

  // word addressed memory, one frame of 128 words
  localparam int ADDR_W      = 7;
  localparam int DATA_W      = 16;
  localparam int BANK_COUNT  = 4;
  localparam int BANK_SEL_W  = 2;
  localparam int BANK_ADDR_W = 5;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // streamer read fsm encoding
  localparam logic [1:0] ST_IDLE      = 2'b00;
  localparam logic [1:0] ST_READ      = 2'b01;
  localparam logic [1:0] ST_READ_WAIT = 2'b10;

  // one sram word, seen either raw or as a 4:4:4 color
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic [3:0] unused;
  } pixel_rgb_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    pixel_rgb_t        rgb;
  } pixel_word_u;

endpackage

//--- vga_sram_pixel_stream.sv
`timescale 1ns/1ps

module vga_sram_pixel_stream (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  axil_read_if.master       rd,
  output logic              hsync,
  output logic              vsync,
  output logic [3:0]        red,
  output logic [3:0]        green,
  output logic [3:0]        blue,
  output logic              valid
);

  logic                          started;
  logic [1:0]                    state;
  logic [1:0]                    next_state;
  logic                          read_start;
  logic                          read_done;
  logic [vga_pkg::COORD_W-1:0]   read_column;
  logic [vga_pkg::COORD_W-1:0]   read_row;
  logic [vga_pkg::ADDR_W-1:0]    pixel_addr;
  logic [vga_pkg::COORD_W-1:0]   vga_column;
  logic [vga_pkg::COORD_W-1:0]   vga_row;
  logic                          vga_visible;

  // stays set once enable has been seen
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      started <= 1'b0;
    end else if (enable) begin
      started <= 1'b1;
    end
  end

  // read side raster position, one step per issued read
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      read_column <= '0;
      read_row    <= '0;
    end else if (read_start) begin
      if (read_column == vga_pkg::H_WHOLE_LINE - 1'b1) begin
        read_column <= '0;
        if (read_row == vga_pkg::V_WHOLE_FRAME - 1'b1) begin
          read_row <= '0;
        end else begin
          read_row <= read_row + 1'b1;
        end
      end else begin
        read_column <= read_column + 1'b1;
      end
    end
  end

  // address walks visible columns only
  // during hblank it points at the next row's first word
  // vblank holds it at 0 so the next frame starts clean
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixel_addr <= '0;
    end else if (read_row >= vga_pkg::V_VISIBLE) begin
      pixel_addr <= '0;
    end else if (read_start && read_column < vga_pkg::H_VISIBLE) begin
      pixel_addr <= pixel_addr + 1'b1;
    end
  end

  // read fsm
  // READ_WAIT leaves once arvalid has dropped, so the address
  // handshake is never missed even when accepted in READ
  always_comb begin
    next_state = state;
    read_start = 1'b0;
    case (state)
      vga_pkg::ST_IDLE: begin
        if (started && enable) begin
          next_state = vga_pkg::ST_READ;
          read_start = 1'b1;
        end
      end
      vga_pkg::ST_READ: begin
        next_state = vga_pkg::ST_READ_WAIT;
      end
      vga_pkg::ST_READ_WAIT: begin
        if (!rd.arvalid) begin
          if (enable) begin
            next_state = vga_pkg::ST_READ;
            read_start = 1'b1;
          end else begin
            next_state = vga_pkg::ST_IDLE;
          end
        end
      end
      default: begin
        next_state = vga_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= vga_pkg::ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // read address channel, arvalid holds until arready
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd.araddr  <= '0;
      rd.arvalid <= 1'b0;
      rd.rready  <= 1'b0;
    end else begin
      // always ready for data once out of reset
      rd.rready <= 1'b1;
      if (read_start) begin
        rd.araddr  <= pixel_addr;
        rd.arvalid <= 1'b1;
      end else if (rd.arready) begin
        rd.arvalid <= 1'b0;
      end
    end
  end

  assign read_done = rd.rvalid && rd.rready;

  // display side position, lags the read side by the memory latency
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_column <= '0;
      vga_row    <= '0;
    end else if (read_done) begin
      if (vga_column == vga_pkg::H_WHOLE_LINE - 1'b1) begin
        vga_column <= '0;
        if (vga_row == vga_pkg::V_WHOLE_FRAME - 1'b1) begin
          vga_row <= '0;
        end else begin
          vga_row <= vga_row + 1'b1;
        end
      end else begin
        vga_column <= vga_column + 1'b1;
      end
    end
  end

  assign vga_visible = (vga_column < vga_pkg::H_VISIBLE) && (vga_row < vga_pkg::V_VISIBLE);

  // all outputs registered on the same edge
  // blanking words are still read but shown black
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      red   <= '0;
      green <= '0;
      blue  <= '0;
      valid <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (read_done) begin
        // syncs are active low
        hsync <= !(vga_column >= vga_pkg::H_SYNC_START && vga_column < vga_pkg::H_SYNC_END);
        vsync <= !(vga_row >= vga_pkg::V_SYNC_START && vga_row < vga_pkg::V_SYNC_END);
        red   <= vga_visible ? rd.rdata.rgb.red : 4'h0;
        green <= vga_visible ? rd.rdata.rgb.green : 4'h0;
        blue  <= vga_visible ? rd.rdata.rgb.blue : 4'h0;
        valid <= 1'b1;
      end
    end
  end

endmodule
